/* composite_defs.svh */
`ifndef COMPOSITE_DEFS_SVH
`define COMPOSITE_DEFS_SVH

// chip model codes, bit 0 set means pal
`define CHIP_6567R8        2'd0
`define CHIP_6569R3        2'd1
`define CHIP_6567R56A      2'd2
`define CHIP_6569R1        2'd3

// raster positions per line
`define LINE_LEN_6567R8    10'd520
`define LINE_LEN_6567R56A  10'd512
`define LINE_LEN_PAL       10'd504

// horizontal offsets, hvisible_end is position 0 on every chip
`define HSYNC_START_NTSC   10'd8
`define HSYNC_START_PAL    10'd7
`define HSYNC_LEN          10'd37
`define HVISIBLE_OFS_NTSC  10'd88
`define HVISIBLE_OFS_PAL   10'd84
// burst begins this many positions after hsync ends
`define BURST_OFS          10'd5

// vertical offsets
`define VVISIBLE_END_NTSC  9'd13
`define VVISIBLE_END_PAL   9'd300
`define VBLANK_LINES       9'd9

// equalization and serration pulse widths
`define EQ_WIDTH           10'd18
`define SE_GAP             10'd37

// output levels
`define BLANKING_LEVEL     6'd12
`define SYNC_LEVEL         6'd0
`define WHITE_LEVEL        6'd63
`define CHROMA_CENTER      6'd32

// colour burst, 9 periods of 16 samples
`define BURST_AMP          4'd12
`define BURST_LEN          8'd144
`define BURST_PHASE_NTSC   8'd128
`define BURST_PHASE_EVEN   8'd96
`define BURST_PHASE_ODD    8'd160

`endif

/* composite_pkg.sv */
`include "composite_defs.svh"

package composite_pkg;

    // horizontal raster position
    typedef logic [9:0] raster_x_t;
    // raster line
    typedef logic [8:0] raster_y_t;
    // 6-bit luma or chroma sample
    typedef logic [5:0] level_t;
    // phase offset, 256 steps per subcarrier period
    typedef logic [7:0] phase_t;
    // amplitude selector, 0 is no modulation
    typedef logic [3:0] amp_t;

    typedef enum logic [1:0] {
        CHIP_6567R8   = `CHIP_6567R8,
        CHIP_6569R3   = `CHIP_6569R3,
        CHIP_6567R56A = `CHIP_6567R56A,
        CHIP_6569R1   = `CHIP_6569R1
    } chip_e;

    typedef enum logic [1:0] {
        BURST_IDLE,
        BURST_ARMED,
        BURST_ACTIVE
    } burst_state_e;

    // decoded raster timing, one cycle behind the raster inputs
    typedef struct packed {
        logic       hsync;
        logic       vsync;
        logic       active;
        logic       first_visible;
        // line within vertical blanking, 15 outside it
        logic [3:0] vblank_idx;
        logic       eq;
        logic       se;
        logic       burst_go;
        logic       new_line;
        logic       pal;
        logic       odd_line;
    } timing_t;

    // sine table request, amplitude on top of the wave address
    typedef struct packed {
        logic [11:0] rom_addr;
        amp_t        amp;
    } chroma_req_t;

endpackage

/* sync_pulse_gen.sv */
`timescale 1ns/100ps
`include "composite_defs.svh"

module sync_pulse_gen (
    input  composite_pkg::raster_x_t raster_x,
    input  composite_pkg::chip_e     chip,
    output logic                     eq,
    output logic                     se
);

    composite_pkg::raster_x_t line_len;
    composite_pkg::raster_x_t half_line;
    composite_pkg::raster_x_t h;

    always_comb begin
        case (chip)
            composite_pkg::CHIP_6567R8:   line_len = `LINE_LEN_6567R8;
            composite_pkg::CHIP_6567R56A: line_len = `LINE_LEN_6567R56A;
            default:                      line_len = `LINE_LEN_PAL;
        endcase
    end

    assign half_line = line_len >> 1;

    // fold the second half line onto the first
    assign h = (raster_x >= half_line) ? raster_x - half_line : raster_x;

    // short equalization pulse at the start of each half line
    assign eq = h < `EQ_WIDTH;

    // broad serration pulse, low only for se_gap before the half line ends
    assign se = h < (half_line - `SE_GAP);

endmodule

/* video_timing_decode.sv */
`timescale 1ns/100ps
`include "composite_defs.svh"

module video_timing_decode (
    input  logic                     clk_col16x,
    input  logic                     rst,
    input  composite_pkg::raster_x_t raster_x,
    input  composite_pkg::raster_y_t raster_y,
    input  composite_pkg::chip_e     chip,
    output composite_pkg::timing_t   timing
);

    composite_pkg::raster_x_t line_len;
    composite_pkg::raster_x_t hsync_start;
    composite_pkg::raster_x_t hsync_end;
    composite_pkg::raster_x_t hvisible_start;
    composite_pkg::raster_x_t burst_start;
    composite_pkg::raster_y_t vvisible_end;
    composite_pkg::raster_y_t vblank_start;
    composite_pkg::raster_y_t vblank_end;
    composite_pkg::raster_y_t vvisible_start;
    composite_pkg::raster_y_t vblank_ofs;
    composite_pkg::raster_y_t prev_y;
    composite_pkg::timing_t   timing_d;
    logic                     pal;
    logic                     in_vblank;
    logic                     vborder;
    logic                     eq;
    logic                     se;

    assign pal = chip[0];

    // per chip offsets
    always_comb begin
        case (chip)
            composite_pkg::CHIP_6567R8:   line_len = `LINE_LEN_6567R8;
            composite_pkg::CHIP_6567R56A: line_len = `LINE_LEN_6567R56A;
            default:                      line_len = `LINE_LEN_PAL;
        endcase
    end

    assign hsync_start    = pal ? `HSYNC_START_PAL : `HSYNC_START_NTSC;
    assign hsync_end      = hsync_start + `HSYNC_LEN;
    assign hvisible_start = hsync_start + (pal ? `HVISIBLE_OFS_PAL : `HVISIBLE_OFS_NTSC);
    assign burst_start    = hsync_end + `BURST_OFS;
    assign vvisible_end   = pal ? `VVISIBLE_END_PAL : `VVISIBLE_END_NTSC;
    // blanking starts one line after the visible end and spans 9 lines
    assign vblank_start   = vvisible_end + 9'd1;
    assign vblank_end     = vblank_start + `VBLANK_LINES - 9'd1;
    assign vvisible_start = vblank_end + 9'd1;

    assign in_vblank  = (raster_y >= vblank_start) && (raster_y <= vblank_end);
    assign vblank_ofs = raster_y - vblank_start;

    // vertical border, wraps from vvisible_end to just past hvisible_start
    assign vborder = (raster_y >= vvisible_end) &&
                     ((raster_y < vvisible_start) ||
                      (raster_y == vvisible_start && raster_x <= hvisible_start));

    sync_pulse_gen u_sync_pulse_gen (
        .raster_x (raster_x),
        .chip     (chip),
        .eq       (eq),
        .se       (se)
    );

    always_comb begin
        timing_d.hsync         = (raster_x >= hsync_start) && (raster_x < hsync_end);
        // vsync window opens at hsync on the first blank line
        // and closes at hsync end on the last one
        timing_d.vsync         = ((raster_y == vblank_start && raster_x >= hsync_start) ||
                                  raster_y > vblank_start) &&
                                 (raster_y < vblank_end ||
                                  (raster_y == vblank_end && raster_x < hsync_end));
        timing_d.active        = (raster_x >= hvisible_start) && !vborder;
        timing_d.first_visible = raster_x == hvisible_start;
        timing_d.vblank_idx    = in_vblank ? vblank_ofs[3:0] : 4'hf;
        timing_d.eq            = eq;
        timing_d.se            = se;
        timing_d.burst_go      = raster_x >= burst_start;
        timing_d.new_line      = raster_y != prev_y;
        timing_d.pal           = pal;
        timing_d.odd_line      = raster_y[0];
    end

    always_ff @(posedge clk_col16x) begin
        if (rst) begin
            prev_y            <= '0;
            timing            <= '0;
            timing.vblank_idx <= 4'hf;
        end else begin
            prev_y <= raster_y;
            timing <= timing_d;
        end
    end

    // raster counter must wrap at the chip's line length
    a_raster_x_range : assert property (@(posedge clk_col16x) disable iff (rst)
        raster_x < line_len);

endmodule

/* luma_gen.sv */
`timescale 1ns/100ps
`include "composite_defs.svh"

module luma_gen (
    input  logic                   clk_col16x,
    input  logic                   rst,
    input  composite_pkg::timing_t timing,
    input  composite_pkg::level_t  luma_code,
    output composite_pkg::level_t  luma_out
);

    composite_pkg::level_t luma_code_q;
    composite_pkg::level_t luma_next;
    composite_pkg::level_t luma_sel;
    composite_pkg::level_t luma_dly;
    logic                  vblank_pulse;

    // lines 3 to 5 of vertical blanking carry serration, the rest equalization
    assign vblank_pulse = (timing.vblank_idx >= 4'd3 && timing.vblank_idx <= 4'd5) ?
                          timing.se : timing.eq;

    always_comb begin
        if (timing.vblank_idx != 4'hf) begin
            luma_next = vblank_pulse ? `SYNC_LEVEL : `BLANKING_LEVEL;
        end else if (timing.hsync) begin
            luma_next = `SYNC_LEVEL;
        end else if (!timing.active) begin
            luma_next = `BLANKING_LEVEL;
        end else if (timing.first_visible) begin
            // single white pixel the chip emits at the left edge
            luma_next = `WHITE_LEVEL;
        end else begin
            luma_next = luma_code_q;
        end
    end

    // pixel code lines up with its own decoded timing
    always_ff @(posedge clk_col16x) begin
        luma_code_q <= luma_code;
    end

    // select, then two stages to match the chroma latency
    always_ff @(posedge clk_col16x) begin
        if (rst) begin
            luma_sel <= `BLANKING_LEVEL;
            luma_dly <= `BLANKING_LEVEL;
            luma_out <= `BLANKING_LEVEL;
        end else begin
            luma_sel <= luma_next;
            luma_dly <= luma_sel;
            luma_out <= luma_dly;
        end
    end

endmodule

/* chroma_gen.sv */
`timescale 1ns/100ps
`include "composite_defs.svh"

module chroma_gen (
    input  logic                       clk_col16x,
    input  logic                       rst,
    input  composite_pkg::timing_t     timing,
    input  composite_pkg::phase_t      phase,
    input  composite_pkg::amp_t        amplitude,
    output composite_pkg::chroma_req_t req
);

    composite_pkg::burst_state_e state;
    composite_pkg::phase_t       phase_q;
    composite_pkg::amp_t         amp_q;
    composite_pkg::amp_t         amp_sel;
    composite_pkg::phase_t       pixel_phase;
    composite_pkg::phase_t       burst_phase;
    composite_pkg::phase_t       phase_sel;
    composite_pkg::phase_t       wave_addr;
    logic [3:0]                  phase_cnt;
    logic [7:0]                  burst_cnt;

    // free running subcarrier phase with 16 samples per period
    always_ff @(posedge clk_col16x) begin
        if (rst) begin
            phase_cnt <= '0;
        end else begin
            phase_cnt <= phase_cnt + 4'd1;
        end
    end

    // pixel values meet their decoded timing one cycle later
    always_ff @(posedge clk_col16x) begin
        if (rst) begin
            amp_q <= '0;
        end else begin
            amp_q <= amplitude;
        end
        phase_q <= phase;
    end

    // burst fsm
    // arms once per line, fires at burst start, runs burst_len samples
    always_ff @(posedge clk_col16x) begin
        if (rst) begin
            state     <= composite_pkg::BURST_IDLE;
            burst_cnt <= '0;
        end else begin
            case (state)
                composite_pkg::BURST_IDLE: begin
                    if (timing.new_line) begin
                        state <= (timing.burst_go && !timing.vsync) ?
                                 composite_pkg::BURST_ACTIVE : composite_pkg::BURST_ARMED;
                    end
                end
                composite_pkg::BURST_ARMED: begin
                    if (timing.burst_go && !timing.vsync) begin
                        state <= composite_pkg::BURST_ACTIVE;
                    end
                end
                composite_pkg::BURST_ACTIVE: begin
                    burst_cnt <= burst_cnt + 8'd1;
                    // vsync cuts the burst short
                    if (timing.vsync || burst_cnt == `BURST_LEN - 8'd1) begin
                        state     <= composite_pkg::BURST_IDLE;
                        burst_cnt <= '0;
                    end
                end
                default: begin
                    state <= composite_pkg::BURST_IDLE;
                end
            endcase
        end
    end

    // no modulation in vsync or at the white pixel
    always_comb begin
        if (timing.vsync) begin
            amp_sel = '0;
        end else if (timing.active) begin
            amp_sel = timing.first_visible ? 4'd0 : amp_q;
        end else if (state == composite_pkg::BURST_ACTIVE) begin
            amp_sel = `BURST_AMP;
        end else begin
            amp_sel = '0;
        end
    end

    // pal swings the pixel phase on alternate lines
    assign pixel_phase = (timing.pal && timing.odd_line) ? 8'd0 - phase_q : phase_q;

    // burst sits at 180 deg for ntsc, 135 and 225 deg for pal
    assign burst_phase = !timing.pal ? `BURST_PHASE_NTSC :
                         (timing.odd_line ? `BURST_PHASE_ODD : `BURST_PHASE_EVEN);

    assign phase_sel = timing.active ? pixel_phase : burst_phase;
    assign wave_addr = {phase_cnt, 4'b0000} + phase_sel;

    always_ff @(posedge clk_col16x) begin
        if (rst) begin
            req <= '0;
        end else begin
            req.rom_addr <= {amp_sel, wave_addr};
            req.amp      <= amp_sel;
        end
    end

    // a burst meets vsync only on the cycle where vsync rises
    // the fsm must have left bursting by the next one
    a_no_burst_in_vsync : assert property (@(posedge clk_col16x) disable iff (rst)
        (state == composite_pkg::BURST_ACTIVE && timing.vsync) |-> $rose(timing.vsync));

    // burst counter stays below burst_len
    a_burst_cnt_bound : assert property (@(posedge clk_col16x) disable iff (rst)
        burst_cnt < `BURST_LEN);

endmodule

/* sine_rom.sv */
`timescale 1ns/100ps
`include "composite_defs.svh"

module sine_rom (
    input  logic                       clk_col16x,
    input  logic                       rst,
    input  composite_pkg::chroma_req_t req,
    output composite_pkg::level_t      chroma_out
);

    // entry k holds round(255 * sin(2 pi (k + 0.5) / 256))
    // half step offset lets the mirrored quadrants use the inverted index
    logic [7:0]          quarter [0:63];
    logic [5:0]          q_idx;
    logic                negative;
    logic [7:0]          mag;
    logic [11:0]         prod;
    logic [11:0]         scaled;
    logic [8:0]          sample;
    logic [8:0]          chroma9;
    composite_pkg::amp_t amp_q;

    initial begin
        $readmemh("sine_quarter.hex", quarter);
    end

    // quadrants 1 and 3 run the table backwards, 2 and 3 are negative
    assign q_idx    = req.rom_addr[6] ? ~req.rom_addr[5:0] : req.rom_addr[5:0];
    assign negative = req.rom_addr[7];
    assign mag      = quarter[q_idx];

    // amplitude out of 15
    assign prod   = mag * req.rom_addr[11:8];
    assign scaled = prod / 12'd15;

    // 9-bit unsigned wave around 256
    assign sample = negative ? 9'd256 - scaled[8:0] : 9'd256 + scaled[8:0];

    always_ff @(posedge clk_col16x) begin
        if (rst) begin
            amp_q <= '0;
        end else begin
            amp_q <= req.amp;
        end
        chroma9 <= sample;
    end

    // zero amplitude parks chroma at centre
    always_ff @(posedge clk_col16x) begin
        if (rst) begin
            chroma_out <= `CHROMA_CENTER;
        end else begin
            chroma_out <= (amp_q == 4'd0) ? `CHROMA_CENTER : chroma9[8:3];
        end
    end

endmodule

/* composite_encoder.sv */
`timescale 1ns/100ps

module composite_encoder (
    input  logic                     clk_col16x,
    input  logic                     rst,
    input  composite_pkg::raster_x_t raster_x,
    input  composite_pkg::raster_y_t raster_y,
    input  composite_pkg::chip_e     chip,
    input  composite_pkg::level_t    luma_code,
    input  composite_pkg::phase_t    phase,
    input  composite_pkg::amp_t      amplitude,
    output composite_pkg::level_t    luma_out,
    output composite_pkg::level_t    chroma_out
);

    composite_pkg::timing_t     timing;
    composite_pkg::chroma_req_t req;

    // raster position to timing flags
    video_timing_decode u_decode (
        .clk_col16x (clk_col16x),
        .rst        (rst),
        .raster_x   (raster_x),
        .raster_y   (raster_y),
        .chip       (chip),
        .timing     (timing)
    );

    // luma with sync, four cycles deep
    luma_gen u_luma (
        .clk_col16x (clk_col16x),
        .rst        (rst),
        .timing     (timing),
        .luma_code  (luma_code),
        .luma_out   (luma_out)
    );

    // subcarrier phase, burst and table address
    chroma_gen u_chroma (
        .clk_col16x (clk_col16x),
        .rst        (rst),
        .timing     (timing),
        .phase      (phase),
        .amplitude  (amplitude),
        .req        (req)
    );

    sine_rom u_sine (
        .clk_col16x (clk_col16x),
        .rst        (rst),
        .req        (req),
        .chroma_out (chroma_out)
    );

endmodule

/* tb_composite_encoder.sv */
`timescale 1ns/100ps
`include "composite_defs.svh"

module tb_composite_encoder;

    // one stimulus row with its expected luma
    typedef struct packed {
        logic [1:0]  chip;
        logic [9:0]  x;
        logic [8:0]  y;
        logic [5:0]  code;
        logic [7:0]  phase;
        logic [3:0]  amp;
        logic [15:0] hold;
        logic [5:0]  exp_luma;
        logic        periodic;
        logic        burst;
    } entry_t;

    logic                     clk_col16x;
    logic                     rst;
    composite_pkg::raster_x_t raster_x;
    composite_pkg::raster_y_t raster_y;
    composite_pkg::chip_e     chip;
    composite_pkg::level_t    luma_code;
    composite_pkg::phase_t    phase;
    composite_pkg::amp_t      amplitude;
    composite_pkg::level_t    luma_out;
    composite_pkg::level_t    chroma_out;

    logic [7:0] sine_tab [0:63];
    entry_t     table_q [$];
    integer     seed;
    int         limit_cycles;
    int         total_cycles;
    int         luma_errors;
    int         chroma_errors;
    int         other_errors;

    // reference model state
    composite_pkg::timing_t      ref_t;
    composite_pkg::timing_t      m_t;
    composite_pkg::burst_state_e m_state;
    composite_pkg::raster_y_t    m_prev_y;
    composite_pkg::amp_t         m_amp;
    composite_pkg::phase_t       m_phase;
    logic [3:0]                  m_cnt;
    logic [7:0]                  m_bcnt;
    int                          amp_sel;
    int                          ph_sel;
    logic [5:0]                  exp_c2;
    logic [5:0]                  exp_c3;
    logic [5:0]                  exp_c4;

    composite_encoder u_dut (
        .clk_col16x (clk_col16x),
        .rst        (rst),
        .raster_x   (raster_x),
        .raster_y   (raster_y),
        .chip       (chip),
        .luma_code  (luma_code),
        .phase      (phase),
        .amplitude  (amplitude),
        .luma_out   (luma_out),
        .chroma_out (chroma_out)
    );

    always #4 clk_col16x = ~clk_col16x;

    // timing flags for one raster position from the chip rules
    function automatic composite_pkg::timing_t decode_ref(input int x, input int y, input int c);
        composite_pkg::timing_t t;
        int pal;
        int len;
        int half;
        int h;
        int hs;
        int he;
        int hv;
        int vve;
        int vb0;
        int vb1;
        int pos;
        pal  = c % 2;
        len  = (c == 0) ? 520 : ((c == 2) ? 512 : 504);
        half = len / 2;
        h    = x % half;
        hs   = pal ? `HSYNC_START_PAL : `HSYNC_START_NTSC;
        he   = hs + `HSYNC_LEN;
        hv   = hs + (pal ? `HVISIBLE_OFS_PAL : `HVISIBLE_OFS_NTSC);
        vve  = pal ? `VVISIBLE_END_PAL : `VVISIBLE_END_NTSC;
        vb0  = vve + 1;
        vb1  = vve + 9;
        // linear position so windows can span line boundaries
        pos  = y * 1024 + x;
        t = '0;
        t.hsync         = (x >= hs) && (x < he);
        t.vsync         = (pos >= vb0 * 1024 + hs) && (pos < vb1 * 1024 + he);
        t.active        = (x >= hv) && !((pos >= vve * 1024) && (pos <= (vb1 + 1) * 1024 + hv));
        t.first_visible = (x == hv);
        t.vblank_idx    = (y >= vb0 && y <= vb1) ? 4'(y - vb0) : 4'hf;
        t.eq            = h < `EQ_WIDTH;
        t.se            = h < half - `SE_GAP;
        t.burst_go      = x >= he + `BURST_OFS;
        t.pal           = (pal == 1);
        t.odd_line      = (y % 2 == 1);
        return t;
    endfunction

    // luma priority runs vblank pulses, hsync, blanking, white pixel, pixel code
    function automatic logic [5:0] luma_ref(input composite_pkg::timing_t t,
                                            input logic [5:0] code);
        logic pulse;
        pulse = (t.vblank_idx >= 3 && t.vblank_idx <= 5) ? t.se : t.eq;
        if (t.vblank_idx != 4'hf) begin
            return pulse ? `SYNC_LEVEL : `BLANKING_LEVEL;
        end
        if (t.hsync) begin
            return `SYNC_LEVEL;
        end
        if (!t.active) begin
            return `BLANKING_LEVEL;
        end
        return t.first_visible ? `WHITE_LEVEL : code;
    endfunction

    // sine lookup by quadrant scaled by amp out of 15
    // result is the top 6 bits of a 9-bit sample
    function automatic int chroma_ref(input int cnt, input int ph, input int amp);
        int addr;
        int quad;
        int idx;
        int v;
        addr = (cnt * 16 + ph) % 256;
        quad = addr / 64;
        idx  = addr % 64;
        if (quad % 2 == 1) begin
            idx = 63 - idx;
        end
        v = sine_tab[idx] * amp / 15;
        if (amp == 0) begin
            return `CHROMA_CENTER;
        end
        return (quad >= 2) ? (256 - v) / 8 : (256 + v) / 8;
    endfunction

    // cycle model of the chroma path with output four edges behind the inputs
    always @(posedge clk_col16x) begin
        if (rst) begin
            m_t            <= '0;
            m_t.vblank_idx <= 4'hf;
            m_state        <= composite_pkg::BURST_IDLE;
            m_prev_y       <= '0;
            m_amp          <= '0;
            m_phase        <= '0;
            m_cnt          <= '0;
            m_bcnt         <= '0;
            exp_c2         <= `CHROMA_CENTER;
            exp_c3         <= `CHROMA_CENTER;
            exp_c4         <= `CHROMA_CENTER;
        end else begin
            ref_t          = decode_ref(raster_x, raster_y, chip);
            ref_t.new_line = raster_y != m_prev_y;
            m_prev_y <= raster_y;
            m_t      <= ref_t;
            m_amp    <= amplitude;
            m_phase  <= phase;
            m_cnt    <= m_cnt + 4'd1;

            // burst arms per line and runs 144 samples unless vsync cuts it
            case (m_state)
                composite_pkg::BURST_IDLE: begin
                    if (m_t.new_line) begin
                        m_state <= (m_t.burst_go && !m_t.vsync) ?
                                   composite_pkg::BURST_ACTIVE : composite_pkg::BURST_ARMED;
                    end
                end
                composite_pkg::BURST_ARMED: begin
                    if (m_t.burst_go && !m_t.vsync) begin
                        m_state <= composite_pkg::BURST_ACTIVE;
                    end
                end
                default: begin
                    if (m_t.vsync || m_bcnt == `BURST_LEN - 1) begin
                        m_state <= composite_pkg::BURST_IDLE;
                        m_bcnt  <= '0;
                    end else begin
                        m_bcnt <= m_bcnt + 8'd1;
                    end
                end
            endcase

            if (m_t.vsync) begin
                amp_sel = 0;
            end else if (m_t.active) begin
                amp_sel = m_t.first_visible ? 0 : m_amp;
            end else if (m_state == composite_pkg::BURST_ACTIVE) begin
                amp_sel = `BURST_AMP;
            end else begin
                amp_sel = 0;
            end

            if (m_t.active) begin
                // pal odd lines run the pixel phase backwards
                ph_sel = (m_t.pal && m_t.odd_line) ? (256 - m_phase) % 256 : m_phase;
            end else if (!m_t.pal) begin
                ph_sel = `BURST_PHASE_NTSC;
            end else begin
                ph_sel = m_t.odd_line ? `BURST_PHASE_ODD : `BURST_PHASE_EVEN;
            end

            exp_c2 <= chroma_ref(m_cnt, ph_sel, amp_sel);
            exp_c3 <= exp_c2;
            exp_c4 <= exp_c3;
        end
    end

    task automatic add_entry(input int c, input int x, input int y, input int amp,
                             input int hold, input bit periodic, input bit burst);
        entry_t e;
        e          = '0;
        e.chip     = c;
        e.x        = x;
        e.y        = y;
        e.code     = $random(seed);
        e.phase    = $random(seed);
        e.amp      = amp;
        e.hold     = hold;
        e.periodic = periodic;
        e.burst    = burst;
        e.exp_luma = luma_ref(decode_ref(x, y, c), e.code);
        table_q.push_back(e);
    endtask

    task automatic build_table();
        int c;
        int l;
        int p;
        int pal;
        int hs;
        int hv;
        int half;
        int vb0;
        int pos_list [0:4];
        for (c = 0; c < 4; c++) begin
            pal  = c % 2;
            hs   = pal ? 7 : 8;
            hv   = pal ? 91 : 96;
            half = (c == 0) ? 260 : ((c == 2) ? 256 : 252);
            vb0  = pal ? 301 : 14;
            // sync, blanking, white pixel and pixel code on a visible line
            add_entry(c, hs + 10, 100, 5, 6, 0, 0);
            add_entry(c, 2, 100, 5, 6, 0, 0);
            add_entry(c, hv, 100, 6, 6, 0, 0);
            add_entry(c, hv + 40, 100, 0, 6, 0, 0);
            add_entry(c, hv + 40, 100, 9, 32, 1, 0);
            add_entry(c, hv + 40, 101, 15, 32, 1, 0);
            // both half lines of every vblank line
            pos_list[0] = 5;
            pos_list[1] = 30;
            pos_list[2] = half - 20;
            pos_list[3] = half + 5;
            pos_list[4] = half + 30;
            for (l = 0; l < 9; l++) begin
                for (p = 0; p < 5; p++) begin
                    add_entry(c, pos_list[p], vb0 + l, 7, 5, 0, 0);
                end
            end
            // quiet line first so any earlier burst has ended
            add_entry(c, 2, 49, 0, 160, 0, 0);
            add_entry(c, 60, 50, 0, 200, 0, 1);
            add_entry(c, 60, 51, 0, 200, 0, 1);
        end
    endtask

    task automatic apply_entry(input entry_t e);
        int         cyc;
        int         k;
        int         off_centre;
        logic [5:0] seen [1:64];
        chip       = composite_pkg::chip_e'(e.chip);
        raster_x   = e.x;
        raster_y   = e.y;
        luma_code  = e.code;
        phase      = e.phase;
        amplitude  = e.amp;
        off_centre = 0;
        for (cyc = 1; cyc <= e.hold; cyc++) begin
            @(posedge clk_col16x);
            #1;
            assert (chroma_out == exp_c4) else begin
                chroma_errors++;
                $display("Mismatch at %0t: chroma_out = %0d, expected %0d",
                         $time, chroma_out, exp_c4);
            end
            if (cyc == 4) begin
                assert (luma_out == e.exp_luma) else begin
                    luma_errors++;
                    $display("Mismatch at %0t: luma_out = %0d, expected %0d",
                             $time, luma_out, e.exp_luma);
                end
            end
            if (cyc <= 64) begin
                seen[cyc] = chroma_out;
            end
            if (chroma_out != `CHROMA_CENTER) begin
                off_centre++;
            end
        end
        // a held pixel repeats with the 16-step subcarrier
        if (e.periodic) begin
            for (k = 4; k <= 16; k++) begin
                assert (seen[k] == seen[k + 16]) else begin
                    other_errors++;
                    $display("chroma_out on line %0d does not repeat after 16 cycles", e.y);
                end
            end
        end
        // one sample per burst period falls on the zero crossing and reads as centre
        if (e.burst) begin
            assert (off_centre == `BURST_LEN - `BURST_LEN / 16) else begin
                other_errors++;
                $display("burst on line %0d left centre for %0d cycles instead of %0d",
                         e.y, off_centre, `BURST_LEN - `BURST_LEN / 16);
            end
        end
    endtask

    // ends a run that stops making progress
    initial begin : watchdog
        wait (limit_cycles > 0);
        repeat (limit_cycles) @(posedge clk_col16x);
        $display("ERROR: run did not finish within %0d cycles", limit_cycles);
        $display("Test failed");
        $finish;
    end

    initial begin
        clk_col16x    = 1'b0;
        rst           = 1'b1;
        raster_x      = '0;
        raster_y      = '0;
        chip          = composite_pkg::CHIP_6567R8;
        luma_code     = '0;
        phase         = '0;
        amplitude     = '0;
        seed          = 38;
        luma_errors   = 0;
        chroma_errors = 0;
        other_errors  = 0;
        limit_cycles  = 0;
        total_cycles  = 0;
        $readmemh("sine_quarter.hex", sine_tab);
        build_table();
        foreach (table_q[i]) begin
            total_cycles += table_q[i].hold;
        end
        // reset, all holds and some slack
        limit_cycles = total_cycles + 8 + 100;

        repeat (8) @(posedge clk_col16x);
        #1;
        rst = 1'b0;

        // idle outputs straight out of reset
        assert (luma_out == `BLANKING_LEVEL) else begin
            luma_errors++;
            $display("Mismatch at %0t: luma_out = %0d, expected %0d",
                     $time, luma_out, `BLANKING_LEVEL);
        end
        assert (chroma_out == `CHROMA_CENTER) else begin
            chroma_errors++;
            $display("Mismatch at %0t: chroma_out = %0d, expected %0d",
                     $time, chroma_out, `CHROMA_CENTER);
        end

        foreach (table_q[i]) begin
            apply_entry(table_q[i]);
        end

        $display("errors: luma %0d, chroma %0d, other %0d",
                 luma_errors, chroma_errors, other_errors);
        if (luma_errors + chroma_errors + other_errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

/* sine_quarter.hex */
// one 8-bit hex value per line, quarter sine magnitude for table index 0 to 63
// value k is round(255 * sin(2 pi (k + 0.5) / 256))
03
09
10
16
1C
22
29
2F
35
3B
41
47
4D
53
59
5F
64
6A
70
75
7B
80
86
8B
90
95
9A
9F
A4
A9
AE
B2
B7
BB
BF
C3
C7
CB
CF
D2
D6
D9
DC
DF
E2
E5
E8
EA
ED
EF
F1
F3
F5
F7
F8
F9
FB
FC
FD
FD
FE
FF
FF
FF

/* composite_encoder.f */
+incdir+.
composite_pkg.sv
sync_pulse_gen.sv
video_timing_decode.sv
luma_gen.sv
chroma_gen.sv
sine_rom.sv
composite_encoder.sv
tb_composite_encoder.sv

/* Bender.yml */
package:
  name: composite_encoder

sources:
  - include_dirs:
      - .
    files:
      - composite_pkg.sv
      - sync_pulse_gen.sv
      - video_timing_decode.sv
      - luma_gen.sv
      - chroma_gen.sv
      - sine_rom.sv
      - composite_encoder.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_composite_encoder.sv
